// File: include/access_params.svh
`ifndef ACCESS_PARAMS_SVH
`define ACCESS_PARAMS_SVH

//////////////////////////////////////////////////
// Keypad codes
//////////////////////////////////////////////////

// Codes above the digits
`define KEY_STAR 4'd10
`define KEY_HASH 4'd11

// Largest code that counts as a digit
`define MAX_DIGIT 4'd9

//////////////////////////////////////////////////
// Users and lockout
//////////////////////////////////////////////////

// Ids and passcodes are packed decimal digits
`define ADMIN_ID 12'h001
`define MAX_USER_ID 12'h018
`define DEFAULT_ADMIN_PASS 16'h1234

// Wrong passcodes in a row before lockout
`define MAX_ERRORS 3

// Alarm length in clock cycles
`define ALARM_HOLD 8

`endif

// File: source/access_pkg.sv
package access_pkg;

	//////////////////////////////////////////////////
	// Keypad side
	//////////////////////////////////////////////////

	typedef logic [3:0] key_code_t;

	// One-cycle strobe per key press
	typedef struct packed {
		logic      strobe;
		key_code_t code;
	} key_event_t;

	// Three and four packed decimal digits
	typedef logic [11:0] user_id_t;
	typedef logic [15:0] passcode_t;

	//////////////////////////////////////////////////
	// User table
	//////////////////////////////////////////////////

	typedef struct packed {
		logic       locked;
		logic [1:0] errors;
		passcode_t  pass;
	} user_entry_t;

	typedef struct packed {
		logic        en;
		user_id_t    id;
		user_entry_t entry;
	} table_wr_t;

	// Controller outputs
	typedef struct packed {
		logic granted;
		logic denied;
		logic locked;
		logic alarm;
	} access_status_t;

endpackage

// File: source/digit_collector.sv
`timescale 1ns/10ps
`include "access_params.svh"

module digit_collector #(
	parameter type payload_t = access_pkg::user_id_t
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   clear,
	input  logic                   enable,
	input  access_pkg::key_event_t key,
	output payload_t               value,
	output logic                   full,
	output logic                   bad_key
);

	localparam int WIDTH = $bits(payload_t);
	localparam int DIGITS = WIDTH / 4;
	localparam int CNT_W = $clog2(DIGITS + 1);

	logic [CNT_W-1:0] count;
	logic [WIDTH-1:0] shreg;
	logic             is_digit;
	logic             shift;

	assign is_digit = key.code <= `MAX_DIGIT;
	assign shift = enable && key.strobe && is_digit && !full;

	// Full once every digit position is taken
	assign full = count == CNT_W'(DIGITS);
	assign value = payload_t'(shreg);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
			bad_key <= 1'b0;
		end else begin
			bad_key <= enable && key.strobe && !is_digit;
			if (clear)
				count <= '0;
			else if (shift)
				count <= count + CNT_W'(1);
		end
	end

	// Newest digit enters at the low nibble
	always_ff @(posedge clk) begin
		if (clear)
			shreg <= '0;
		else if (shift)
			shreg <= {shreg[WIDTH-5:0], key.code};
	end

	// One key strobe gives at most one bad key pulse
	bad_key_one_cycle: assert property (
		@(posedge clk) disable iff (rst)
		bad_key |=> !bad_key
	);

endmodule

// File: source/user_table.sv
`timescale 1ns/10ps
`include "access_params.svh"

module user_table (
	input  logic                    clk,
	input  logic                    rst,
	input  access_pkg::user_id_t    rd_id,
	output access_pkg::user_entry_t rd_entry,
	input  access_pkg::table_wr_t   wr
);

	localparam int IDX_W = 5;
	localparam int DEPTH = 2 ** IDX_W;

	// Low two decimal digits turned into a binary index
	function automatic logic [IDX_W-1:0] id_index(input access_pkg::user_id_t id);
		return IDX_W'(id[7:4]) * IDX_W'(10) + IDX_W'(id[3:0]);
	endfunction

	localparam logic [IDX_W-1:0] ADMIN_IDX = id_index(`ADMIN_ID);

	logic [DEPTH-1:0]      locked_q;
	logic [DEPTH-1:0]      written_q;
	access_pkg::passcode_t pass_mem [DEPTH];
	logic [1:0]            err_mem [DEPTH];
	logic [IDX_W-1:0]      rd_idx;
	logic [IDX_W-1:0]      wr_idx;

	assign rd_idx = id_index(rd_id);
	assign wr_idx = id_index(wr.id);

	//////////////////////////////////////////////////
	// Lock and written flags
	//////////////////////////////////////////////////

	// Everyone but the administrator starts locked
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			locked_q <= ~(DEPTH'(1) << ADMIN_IDX);
			written_q <= '0;
		end else if (wr.en) begin
			locked_q[wr_idx] <= wr.entry.locked;
			written_q[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr.en) begin
			pass_mem[wr_idx] <= wr.entry.pass;
			err_mem[wr_idx] <= wr.entry.errors;
		end
	end

	//////////////////////////////////////////////////
	// Registered read
	//////////////////////////////////////////////////

	// Records never written read as zero errors, admin gets the default passcode
	always_ff @(posedge clk) begin
		rd_entry.locked <= locked_q[rd_idx];
		if (written_q[rd_idx]) begin
			rd_entry.errors <= err_mem[rd_idx];
			rd_entry.pass <= pass_mem[rd_idx];
		end else begin
			rd_entry.errors <= 2'd0;
			rd_entry.pass <= (rd_idx == ADMIN_IDX) ? `DEFAULT_ADMIN_PASS : '0;
		end
	end

	// The controller range-checks every id before writing
	wr_id_in_range: assert property (
		@(posedge clk) disable iff (rst)
		wr.en |-> (wr.id != '0) && (wr.id <= `MAX_USER_ID)
	);

endmodule

// File: source/alarm_timer.sv
`timescale 1ns/10ps
`include "access_params.svh"

module alarm_timer (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic active,
	output logic done
);

	localparam int CNT_W = $clog2(`ALARM_HOLD + 1);

	logic [CNT_W-1:0] count;

	// Loaded on start, runs down to zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			count <= '0;
		else if (start)
			count <= CNT_W'(`ALARM_HOLD);
		else if (count != '0)
			count <= count - CNT_W'(1);
	end

	assign active = count != '0;

	// Last cycle of the hold
	assign done = count == CNT_W'(1);

	done_after_start: assert property (
		@(posedge clk) disable iff (rst)
		start |-> ##(`ALARM_HOLD) done
	);

endmodule

// File: source/access_fsm.sv
`timescale 1ns/10ps
`include "access_params.svh"

module access_fsm (
	input  logic                       clk,
	input  logic                       rst,
	input  access_pkg::key_event_t     key,
	input  access_pkg::user_id_t       id_value,
	input  logic                       id_full,
	output logic                       id_clear,
	output logic                       id_enable,
	input  access_pkg::passcode_t      pass_value,
	input  logic                       pass_full,
	output logic                       pass_clear,
	output logic                       pass_enable,
	input  logic                       bad_key,
	output access_pkg::user_id_t       rd_id,
	input  access_pkg::user_entry_t    rd_entry,
	output access_pkg::table_wr_t      wr,
	output logic                       alarm_start,
	input  logic                       alarm_done,
	input  logic                       alarm_active,
	output access_pkg::access_status_t status
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_ID,
		S_ID_CHECK,
		S_WAIT_STAR,
		S_PASS,
		S_PASS_CHECK,
		S_ADMIN,
		S_NEW_ID,
		S_NEW_PASS,
		S_COMMIT,
		S_ALARM
	} state_t;

	state_t     state;
	state_t     next_state;
	logic       star_key;
	logic       hash_key;
	logic       id_ok;
	logic       pass_match;
	logic       is_admin;
	logic       lock_now;
	logic [2:0] err_inc;
	logic       granted_q;
	logic       denied_q;
	logic       locked_q;

	assign star_key = key.strobe && (key.code == `KEY_STAR);
	assign hash_key = key.strobe && (key.code == `KEY_HASH);

	// Valid ids run from 001 up to the last user
	assign id_ok = (id_value != '0) && (id_value <= `MAX_USER_ID);
	assign is_admin = id_value == `ADMIN_ID;
	assign pass_match = pass_value == rd_entry.pass;
	assign err_inc = {1'b0, rd_entry.errors} + 3'd1;
	assign lock_now = err_inc >= 3'(`MAX_ERRORS);

	// Table always looks at the id being collected
	assign rd_id = id_value;

	//////////////////////////////////////////////////
	// State sequence
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:
				if (star_key)
					next_state = S_ID;
			S_ID:
				if (bad_key)
					next_state = S_ALARM;
				else if (id_full)
					next_state = S_ID_CHECK;
			// Table entry for the new id is valid here
			S_ID_CHECK:
				if (!id_ok)
					next_state = S_IDLE;
				else if (rd_entry.locked)
					next_state = S_ALARM;
				else
					next_state = S_WAIT_STAR;
			S_WAIT_STAR:
				if (star_key)
					next_state = S_PASS;
			S_PASS:
				if (bad_key)
					next_state = S_ALARM;
				else if (pass_full)
					next_state = S_PASS_CHECK;
			S_PASS_CHECK:
				if (pass_match)
					next_state = is_admin ? S_ADMIN : S_IDLE;
				else
					next_state = lock_now ? S_ALARM : S_IDLE;
			// Admin menu where hash enrolls and star leaves
			S_ADMIN:
				if (hash_key)
					next_state = S_NEW_ID;
				else if (star_key)
					next_state = S_IDLE;
			S_NEW_ID:
				if (bad_key)
					next_state = S_ALARM;
				else if (id_full)
					next_state = id_ok ? S_NEW_PASS : S_IDLE;
			S_NEW_PASS:
				if (bad_key)
					next_state = S_ALARM;
				else if (pass_full)
					next_state = S_COMMIT;
			S_COMMIT:
				if (star_key)
					next_state = S_IDLE;
			S_ALARM:
				if (alarm_done)
					next_state = S_IDLE;
			default:
				next_state = S_IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// Collector and timer control
	//////////////////////////////////////////////////

	assign id_clear = (state == S_IDLE && star_key) || (state == S_ADMIN && hash_key);
	assign pass_clear = (state == S_WAIT_STAR && star_key) || (state == S_ADMIN && hash_key);
	assign id_enable = (state == S_ID) || (state == S_NEW_ID);
	assign pass_enable = (state == S_PASS) || (state == S_NEW_PASS);
	assign alarm_start = (next_state == S_ALARM) && (state != S_ALARM);

	// Table updates for a login result or an enrollment commit
	always_comb begin
		wr = '0;
		wr.id = id_value;
		if (state == S_PASS_CHECK) begin
			wr.en = 1'b1;
			wr.entry.pass = rd_entry.pass;
			wr.entry.locked = !pass_match && lock_now;
			wr.entry.errors = pass_match ? 2'd0 : err_inc[1:0];
		end else if (state == S_COMMIT && star_key) begin
			wr.en = 1'b1;
			wr.entry.pass = pass_value;
		end
	end

	//////////////////////////////////////////////////
	// Status pulses
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			granted_q <= 1'b0;
			denied_q <= 1'b0;
			locked_q <= 1'b0;
		end else begin
			granted_q <= (state == S_PASS_CHECK) && pass_match;
			denied_q <= (state == S_PASS_CHECK) && !pass_match && !lock_now;
			locked_q <= (state == S_PASS_CHECK) && !pass_match && lock_now;
		end
	end

	assign status = '{
		granted: granted_q,
		denied: denied_q,
		locked: locked_q,
		alarm: alarm_active
	};

	// No login result while the alarm holds
	grant_deny_outside_alarm: assert property (
		@(posedge clk) disable iff (rst)
		(status.granted || status.denied) |-> !status.alarm
	);

endmodule

// File: source/elevator_access.sv
`timescale 1ns/10ps

module elevator_access (
	input  logic                       clk,
	input  logic                       rst,
	input  access_pkg::key_event_t     key,
	output access_pkg::access_status_t status
);

	access_pkg::user_id_t    id_value;
	logic                    id_full;
	logic                    id_clear;
	logic                    id_enable;
	logic                    id_bad;
	access_pkg::passcode_t   pass_value;
	logic                    pass_full;
	logic                    pass_clear;
	logic                    pass_enable;
	logic                    pass_bad;
	access_pkg::user_id_t    rd_id;
	access_pkg::user_entry_t rd_entry;
	access_pkg::table_wr_t   wr;
	logic                    alarm_start;
	logic                    alarm_done;
	logic                    alarm_active;

	// Three-digit user id
	digit_collector #(
		.payload_t(access_pkg::user_id_t)
	) id_collector_i (
		.clk(clk),
		.rst(rst),
		.clear(id_clear),
		.enable(id_enable),
		.key(key),
		.value(id_value),
		.full(id_full),
		.bad_key(id_bad)
	);

	// Four-digit passcode
	digit_collector #(
		.payload_t(access_pkg::passcode_t)
	) pass_collector_i (
		.clk(clk),
		.rst(rst),
		.clear(pass_clear),
		.enable(pass_enable),
		.key(key),
		.value(pass_value),
		.full(pass_full),
		.bad_key(pass_bad)
	);

	user_table user_table_i (
		.clk(clk),
		.rst(rst),
		.rd_id(rd_id),
		.rd_entry(rd_entry),
		.wr(wr)
	);

	alarm_timer alarm_timer_i (
		.clk(clk),
		.rst(rst),
		.start(alarm_start),
		.active(alarm_active),
		.done(alarm_done)
	);

	access_fsm access_fsm_i (
		.clk(clk),
		.rst(rst),
		.key(key),
		.id_value(id_value),
		.id_full(id_full),
		.id_clear(id_clear),
		.id_enable(id_enable),
		.pass_value(pass_value),
		.pass_full(pass_full),
		.pass_clear(pass_clear),
		.pass_enable(pass_enable),
		.bad_key(id_bad | pass_bad),
		.rd_id(rd_id),
		.rd_entry(rd_entry),
		.wr(wr),
		.alarm_start(alarm_start),
		.alarm_done(alarm_done),
		.alarm_active(alarm_active),
		.status(status)
	);

endmodule

// File: dv/elevator_access_tb.sv
`timescale 1ns/10ps
`include "access_params.svh"

module elevator_access_tb;

	localparam int KEY_GAP = 6;
	localparam int WAIT_LIMIT = 40;

	logic                       clk;
	logic                       rst;
	access_pkg::key_event_t     key;
	access_pkg::access_status_t status;

	// Reference user table, indexed by the decimal value of the id
	logic                  ref_locked [100];
	logic [1:0]            ref_errors [100];
	access_pkg::passcode_t ref_pass [100];

	access_pkg::access_status_t exp_q [$];
	integer seed = 32'habbc;
	int     cycle_cnt = 0;
	int     last_key_cycle = 0;
	int     alarm_age = 0;
	logic   alarm_prev = 1'b0;
	int     checks = 0;
	int     value_errors = 0;
	int     window_errors = 0;
	int     timeouts = 0;

	elevator_access dut_i (
		.clk(clk),
		.rst(rst),
		.key(key),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic int id_to_int(input access_pkg::user_id_t id);
		return int'(id[7:4]) * 10 + int'(id[3:0]);
	endfunction

	function automatic void ref_reset();
		for (int i = 0; i < 100; i++) begin
			ref_locked[i] = 1'b1;
			ref_errors[i] = 2'd0;
			ref_pass[i] = '0;
		end
		ref_locked[id_to_int(`ADMIN_ID)] = 1'b0;
		ref_pass[id_to_int(`ADMIN_ID)] = `DEFAULT_ADMIN_PASS;
	endfunction

	// Expected status event for one login attempt, table updated on the way
	function automatic access_pkg::access_status_t ref_login(input access_pkg::user_id_t id,
			input access_pkg::passcode_t pass);
		access_pkg::access_status_t ev;
		int n;
		ev = '0;
		n = id_to_int(id);
		if (id == '0 || id > `MAX_USER_ID)
			return ev;
		if (ref_locked[n]) begin
			ev.alarm = 1'b1;
		end else if (pass == ref_pass[n]) begin
			ev.granted = 1'b1;
			ref_errors[n] = 2'd0;
		end else if (int'(ref_errors[n]) + 1 >= `MAX_ERRORS) begin
			ev.locked = 1'b1;
			ev.alarm = 1'b1;
			ref_locked[n] = 1'b1;
		end else begin
			ev.denied = 1'b1;
			ref_errors[n] = ref_errors[n] + 2'd1;
		end
		return ev;
	endfunction

	function automatic void ref_enroll(input access_pkg::user_id_t id,
			input access_pkg::passcode_t pass);
		ref_locked[id_to_int(id)] = 1'b0;
		ref_errors[id_to_int(id)] = 2'd0;
		ref_pass[id_to_int(id)] = pass;
	endfunction

	function automatic int random_below(input int limit);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % limit;
	endfunction

	function automatic access_pkg::passcode_t random_passcode();
		access_pkg::passcode_t p;
		p = '0;
		for (int i = 0; i < 4; i++)
			p = {p[11:0], 4'(random_below(10))};
		return p;
	endfunction

	function automatic access_pkg::passcode_t wrong_pass(input access_pkg::passcode_t right);
		access_pkg::passcode_t p;
		p = random_passcode();
		if (p == right)
			p[3:0] = (p[3:0] == 4'd9) ? 4'd0 : p[3:0] + 4'd1;
		return p;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks and monitor
	//////////////////////////////////////////////////

	task automatic check_status(input string name, input access_pkg::access_status_t want,
			input access_pkg::access_status_t got);
		checks++;
		if (got !== want) begin
			value_errors++;
			$display("ERROR %0t ns: %s expected %b, got %b", $time, name, want, got);
		end
	endtask

	task automatic check_logic(input string name, input logic want, input logic got);
		checks++;
		if (got !== want) begin
			value_errors++;
			$display("ERROR %0t ns: %s expected %b, got %b", $time, name, want, got);
		end
	endtask

	// Status pulses, with the alarm reduced to its rising edge
	always @(negedge clk) begin : monitor
		access_pkg::access_status_t got;
		access_pkg::access_status_t want;
		int lat;
		got = status;
		got.alarm = status.alarm && !alarm_prev;
		// Alarm length may be off by one cycle either way
		if (alarm_age != 0) begin
			if (alarm_age < `ALARM_HOLD - 1)
				check_logic("status.alarm", 1'b1, status.alarm);
			else if (alarm_age == `ALARM_HOLD + 1)
				check_logic("status.alarm", 1'b0, status.alarm);
			alarm_age = (alarm_age == `ALARM_HOLD + 1) ? 0 : alarm_age + 1;
		end
		if (got.alarm)
			alarm_age = 1;
		alarm_prev = status.alarm;
		if (got != '0) begin
			if (exp_q.size() == 0) begin
				check_status("status", '0, got);
			end else begin
				want = exp_q.pop_front();
				check_status("status", want, got);
				lat = cycle_cnt - last_key_cycle;
				if (lat < ((want.granted || want.denied) ? 2 : 1) || lat > 3) begin
					window_errors++;
					$display("Status event %b at %0t ns came %0d cycles after the last key",
						got, $time, lat);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Key stimulus
	//////////////////////////////////////////////////

	task automatic send_key(input access_pkg::key_code_t code);
		@(negedge clk);
		key.strobe = 1'b1;
		key.code = code;
		last_key_cycle = cycle_cnt + 1;
		@(negedge clk);
		key = '0;
		repeat (KEY_GAP - 2) @(negedge clk);
	endtask

	task automatic send_id(input access_pkg::user_id_t id);
		send_key(id[11:8]);
		send_key(id[7:4]);
		send_key(id[3:0]);
	endtask

	task automatic send_pass(input access_pkg::passcode_t pass);
		for (int i = 3; i >= 0; i--)
			send_key(pass[i*4 +: 4]);
	endtask

	// Until every expected event has arrived and the alarm is over
	task automatic wait_quiet();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || alarm_age != 0 || alarm_prev) && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0 || alarm_age != 0 || alarm_prev) begin
			timeouts++;
			$display("Timeout at %0t ns: %0d status events missing or the alarm never ended",
				$time, exp_q.size());
			exp_q.delete();
		end
	endtask

	// The passcode is only sent when the id gets past the check
	task automatic login(input access_pkg::user_id_t id, input access_pkg::passcode_t pass);
		access_pkg::access_status_t ev;
		ev = ref_login(id, pass);
		if (ev != '0)
			exp_q.push_back(ev);
		send_key(`KEY_STAR);
		send_id(id);
		if (ev.granted || ev.denied || ev.locked) begin
			send_key(`KEY_STAR);
			send_pass(pass);
		end
		wait_quiet();
	endtask

	task automatic leave_admin();
		send_key(`KEY_STAR);
		wait_quiet();
	endtask

	task automatic enroll(input access_pkg::user_id_t id, input access_pkg::passcode_t pass);
		login(`ADMIN_ID, ref_pass[id_to_int(`ADMIN_ID)]);
		send_key(`KEY_HASH);
		send_id(id);
		send_pass(pass);
		send_key(`KEY_STAR);
		ref_enroll(id, pass);
		wait_quiet();
	endtask

	task automatic bad_id_key();
		access_pkg::access_status_t ev;
		ev = '0;
		ev.alarm = 1'b1;
		exp_q.push_back(ev);
		send_key(`KEY_STAR);
		send_key(4'd5);
		send_key(`KEY_HASH);
		wait_quiet();
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : stimulus
		access_pkg::user_id_t  user_id;
		access_pkg::passcode_t user_pass;
		int                    n;
		key = '0;
		rst = 1'b1;
		ref_reset();
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_status("status", '0, status);

		// Admin with the default passcode
		login(`ADMIN_ID, `DEFAULT_ADMIN_PASS);
		leave_admin();

		// Enroll a random user, then log in
		n = 2 + random_below(17);
		user_id = {4'd0, 4'(n / 10), 4'(n % 10)};
		user_pass = random_passcode();
		enroll(user_id, user_pass);
		login(user_id, user_pass);

		// Error count clears on success
		login(user_id, wrong_pass(user_pass));
		login(user_id, wrong_pass(user_pass));
		login(user_id, user_pass);
		login(user_id, wrong_pass(user_pass));
		login(user_id, wrong_pass(user_pass));

		// Lockout, locked login, then re-enroll
		login(user_id, user_pass);
		repeat (3) login(user_id, wrong_pass(user_pass));
		login(user_id, user_pass);
		user_pass = random_passcode();
		enroll(user_id, user_pass);
		login(user_id, user_pass);

		// Non-digit during id entry
		bad_id_key();
		login(user_id, user_pass);

		// Never enrolled, then out of range
		n = (n == 18) ? 17 : 18;
		login({4'd0, 4'(n / 10), 4'(n % 10)}, random_passcode());
		login(12'h000, random_passcode());
		login(12'h019, random_passcode());
		login(12'h020, random_passcode());

		$display("Checks: %0d, value errors: %0d, window errors: %0d, timeouts: %0d",
			checks, value_errors, window_errors, timeouts);
		if (value_errors + window_errors + timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: all.f
+incdir+include
source/access_pkg.sv
source/digit_collector.sv
source/user_table.sv
source/alarm_timer.sv
source/access_fsm.sv
source/elevator_access.sv
dv/elevator_access_tb.sv

// File: Makefile
# Verilator build and run for the elevator access controller

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f all.f --top-module elevator_access_tb -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
